// File: compile.f
rtl/pool_pkg.sv
rtl/pool_ctrl_if.sv
rtl/pool_control.sv
rtl/pool_datapath.sv
rtl/pool_axil_regs.sv
rtl/pool_top.sv
tb/pool_tb.sv

// File: rtl/pool_axil_regs.sv
`timescale 1ns/1ps

module pool_axil_regs
    import pool_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic                  run_finish,
    input  logic                  pool_valid,
    output logic                  run_start
);

    logic                  busy;
    logic                  done;
    logic [OUT_CNT_W-1:0]  out_count;
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  start_req;
    logic [AXI_DATA_W-1:0] rd_word;

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    // only the low byte of the control word carries the start bit
    assign start_req = wr_fire && (awaddr == REG_CTRL) && wstrb[0]
                       && wdata[CTRL_START_BIT] && !busy;

    assign bresp = AXI_RESP_OKAY;
    assign rresp = AXI_RESP_OKAY;

    always_comb
    begin
        rd_word = '0;   // unmapped offsets read as zero
        case (araddr)
            REG_STATUS:
            begin
                rd_word[STATUS_BUSY_BIT] = busy;
                rd_word[STATUS_DONE_BIT] = done;
            end
            REG_OUT_COUNT: rd_word[OUT_CNT_W-1:0] = out_count;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            // both ready flags rise for one cycle once address and data are present
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            arready <= arvalid && !rvalid && !arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
            rdata <= rd_word;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            run_start <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            out_count <= '0;
        end
        else
        begin
            run_start <= start_req;
            if (start_req)
            begin
                busy      <= 1'b1;
                done      <= 1'b0;
                out_count <= '0;
            end
            else
            begin
                if (run_finish)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;   // sticky until the next start
                end
                if (pool_valid)
                    out_count <= out_count + 1'b1;
            end
        end
    end

endmodule

// File: rtl/pool_control.sv
`timescale 1ns/1ps

module pool_control
    import pool_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      run_start,
    input  logic      pix_valid,
    output logic      run_finish,
    pool_ctrl_if.ctrl ctl
);

    // even input rows fill the buffer, odd rows combine with it
    enum logic [1:0] {
        idle      = 2'b00,
        buffering = 2'b01,
        working   = 2'b10,
        finished  = 2'b11
    } state, state_nxt;

    logic [CNT_W-1:0] col;
    logic [CNT_W-1:0] col_nxt;
    logic [CNT_W-1:0] row;
    logic [CNT_W-1:0] row_nxt;
    logic             active;
    logic             step;
    logic             last_col;
    logic             last_row;
    logic             odd_done;
    logic             even_done;

    assign active   = (state == buffering) || (state == working);
    assign step     = pix_valid && active;   // nothing moves in a gap of the stream
    assign last_col = (col == CNT_W'(MAP_SIZE - 1));
    assign last_row = (row == CNT_W'(MAP_SIZE - 1));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state      <= idle;
            col        <= '0;
            row        <= '0;
            run_finish <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            col        <= col_nxt;
            row        <= row_nxt;
            run_finish <= (state == finished);   // lands with the last pooled value
        end
    end

    always_comb
    begin
        state_nxt = state;
        col_nxt   = col;
        row_nxt   = row;
        case (state)
            idle:
            begin
                col_nxt = '0;
                row_nxt = '0;
                if (run_start)
                    state_nxt = buffering;
            end
            buffering, working:
            begin
                if (step)
                begin
                    if (last_col)
                    begin
                        col_nxt = '0;
                        row_nxt = row + 1'b1;
                        if (state == buffering)
                            state_nxt = working;
                        else if (last_row)
                            state_nxt = finished;
                        else
                            state_nxt = buffering;
                    end
                    else
                    begin
                        col_nxt = col + 1'b1;
                    end
                end
            end
            finished:
            begin
                state_nxt = idle;
            end
            default:
            begin
                state_nxt = idle;
            end
        endcase
    end

    // a block held in the spare entry completes on the next accepted value
    assign odd_done  = step && (state == working) && !col[0] && (col != '0);
    // the last block of an odd row is emitted on the first value of the next row
    assign even_done = step && (state == buffering) && (col == '0) && (row != '0);

    assign ctl.pix_step  = step;
    assign ctl.pair_sel  = col[0];
    assign ctl.wr_adrs   = col[BUF_ADDR_W:1];
    assign ctl.rd_adrs   = (col == '0) ? BUF_ADDR_W'(OUT_SIZE - 1)
                                       : col[BUF_ADDR_W:1] - 1'b1;
    assign ctl.buf_wr    = step && (state == buffering) && col[0];
    assign ctl.hold_wr   = step && (state == working) && col[0];
    assign ctl.pool_done = odd_done || even_done || (state == finished);

endmodule

// File: rtl/pool_ctrl_if.sv
`timescale 1ns/1ps

// row buffer addressing and strobes from the FSM to the datapath
interface pool_ctrl_if
    import pool_pkg::*;
();

    logic                  pix_step;
    logic [BUF_ADDR_W-1:0] wr_adrs;
    logic [BUF_ADDR_W-1:0] rd_adrs;
    logic                  pair_sel;   // high on the second value of a horizontal pair
    logic                  hold_wr;
    logic                  buf_wr;
    logic                  pool_done;

    modport ctrl (
        output pix_step, wr_adrs, rd_adrs, pair_sel, hold_wr, buf_wr, pool_done
    );

    modport dp (
        input pix_step, wr_adrs, rd_adrs, pair_sel, hold_wr, buf_wr, pool_done
    );

endinterface

// File: rtl/pool_datapath.sv
`timescale 1ns/1ps

module pool_datapath
    import pool_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic [DATA_W-1:0] pix_data,
    output logic              pool_valid,
    output logic [DATA_W-1:0] pool_data,
    pool_ctrl_if.dp           ctl
);

    logic [DATA_W-1:0] pair_q;
    logic [DATA_W-1:0] pair_max;
    logic [DATA_W-1:0] block_max;
    logic [DATA_W-1:0] row_buf [BUF_DEPTH];

    // all values are two's complement
    function automatic logic [DATA_W-1:0] smax(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        logic a_wins;
        a_wins = ($signed(a) > $signed(b));
        return a_wins ? a : b;
    endfunction

    assign pair_max = smax(pair_q, pix_data);

    // first value of a pair is loaded, the second one is compared in
    always_ff @(posedge clk)
    begin
        if (ctl.pix_step)
        begin
            if (ctl.pair_sel)
                pair_q <= pair_max;
            else
                pair_q <= pix_data;
        end
    end

    // even rows store per column, odd rows park the pair in the spare entry
    always_ff @(posedge clk)
    begin
        if (ctl.buf_wr)
            row_buf[ctl.wr_adrs] <= pair_max;
        else if (ctl.hold_wr)
            row_buf[SPARE_ADR] <= pair_max;
    end

    // spare holds the lower pair, rd_adrs points at the upper pair of the block
    assign block_max = smax(row_buf[SPARE_ADR], row_buf[ctl.rd_adrs]);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            pool_valid <= 1'b0;
        else
            pool_valid <= ctl.pool_done;
    end

    always_ff @(posedge clk)
    begin
        if (ctl.pool_done)
            pool_data <= block_max;
    end

endmodule

// File: rtl/pool_pkg.sv
package pool_pkg;

    // input and pooled map geometry
    localparam int MAP_SIZE = 28;
    localparam int OUT_SIZE = MAP_SIZE / 2;
    localparam int DATA_W   = 16;   // signed values from the systolic array
    localparam int CNT_W    = 5;    // column and row counters, 0 to 27

    // row buffer keeps one pair maximum per output column
    localparam int BUF_ADDR_W = 4;
    localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;

    // the top entry parks the pair of an odd row, entry 14 is never touched
    localparam logic [BUF_ADDR_W-1:0] SPARE_ADR = 4'hf;

    // AXI4-Lite bus geometry
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // register map
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_OUT_COUNT = 4'h8;

    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // 196 pooled values fit in one byte
    localparam int OUT_CNT_W = 8;

endpackage

// File: rtl/pool_top.sv
`timescale 1ns/1ps

module pool_top
    import pool_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic                  pix_valid,
    input  logic [DATA_W-1:0]     pix_data,
    output logic                  pool_valid,
    output logic [DATA_W-1:0]     pool_data
);

    logic run_start;
    logic run_finish;

    pool_ctrl_if ctl_if ();

    pool_control u_control (
        .clk        (clk),
        .nrst       (nrst),
        .run_start  (run_start),
        .pix_valid  (pix_valid),
        .run_finish (run_finish),
        .ctl        (ctl_if.ctrl)
    );

    pool_datapath u_datapath (
        .clk        (clk),
        .nrst       (nrst),
        .pix_data   (pix_data),
        .pool_valid (pool_valid),
        .pool_data  (pool_data),
        .ctl        (ctl_if.dp)
    );

    // pool_valid also drives the output counter in the register block
    pool_axil_regs u_regs (
        .clk        (clk),
        .nrst       (nrst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .run_finish (run_finish),
        .pool_valid (pool_valid),
        .run_start  (run_start)
    );

endmodule

// File: tb/pool_tb.sv
`timescale 1ns/1ps

module pool_tb
    import pool_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  nrst;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  pix_valid;
    logic [DATA_W-1:0]     pix_data;
    logic                  pool_valid;
    logic [DATA_W-1:0]     pool_data;

    logic signed [DATA_W-1:0] map [MAP_SIZE*MAP_SIZE];
    logic [DATA_W-1:0]        expect_q [$];   // block maxima in row-major order
    int unsigned              seed;

    pool_top dut0 (
        .clk        (clk),
        .nrst       (nrst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pool_valid (pool_valid),
        .pool_data  (pool_data)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: %s, got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             input int resp_delay);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(negedge clk);   // handshake took place on the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check(bresp, AXI_RESP_OKAY, "write response code");
        repeat (resp_delay) @(negedge clk);
        check(bvalid, 1, "write response valid");
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int resp_delay,
                            output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        check(rresp, AXI_RESP_OKAY, "read response code");
        repeat (resp_delay) @(negedge clk);
        check(rvalid, 1, "read data valid");
        data   = rdata;   // held until the next read is accepted
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // extreme maps rotate blocks between all negative, min/max mixes and plain random
    task automatic fill_map(input bit extreme);
        int r;
        int c;
        int kind;
        for (r = 0; r < MAP_SIZE; r++)
        begin
            for (c = 0; c < MAP_SIZE; c++)
            begin
                kind = extreme ? ((r / 2) * OUT_SIZE + c / 2) % 3 : 2;
                case (kind)
                    0:       map[r*MAP_SIZE+c] = {1'b1, 15'($urandom)};
                    1:       map[r*MAP_SIZE+c] = ($urandom % 2) ? 16'h8000 : 16'h7fff;
                    default: map[r*MAP_SIZE+c] = 16'($urandom);
                endcase
            end
        end
    endtask

    task automatic build_model();
        int br;
        int bc;
        int dr;
        int dc;
        int v;
        int best;
        for (br = 0; br < OUT_SIZE; br++)
        begin
            for (bc = 0; bc < OUT_SIZE; bc++)
            begin
                best = -32769;   // below every 16-bit signed value
                for (dr = 0; dr < 2; dr++)
                begin
                    for (dc = 0; dc < 2; dc++)
                    begin
                        v = map[(2 * br + dr) * MAP_SIZE + 2 * bc + dc];
                        if (v > best)
                            best = v;
                    end
                end
                expect_q.push_back(16'(best));
            end
        end
    endtask

    task automatic stream_map(input int gap_pct);
        int i;
        i = 0;
        while (i < MAP_SIZE * MAP_SIZE)
        begin
            @(negedge clk);
            if (($urandom % 100) < gap_pct)
            begin
                pix_valid = 1'b0;
                pix_data  = 16'($urandom);   // junk in a gap must be ignored
            end
            else
            begin
                pix_valid = 1'b1;
                pix_data  = map[i];
                i++;
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic finish_run();
        logic [31:0] rd;
        rd = '0;
        while (!rd[STATUS_DONE_BIT])
            axi_read(REG_STATUS, 0, rd);
        check(rd, 32'h2, "status after run");
        axi_read(REG_OUT_COUNT, 0, rd);
        check(rd, OUT_SIZE * OUT_SIZE, "output count after run");
        check(expect_q.size(), 0, "pooled values still expected");
    endtask

    task automatic do_run(input bit extreme, input int gap_pct);
        fill_map(extreme);
        build_model();
        axi_write(REG_CTRL, 32'h1, 0);
        stream_map(gap_pct);
        finish_run();
    endtask

    // register traffic with slow responses while the pixel stream keeps going
    task automatic access_regs_during_run();
        logic [31:0] rd;
        repeat (20) @(negedge clk);
        axi_read(REG_STATUS, $urandom % 6, rd);
        check(rd, 32'h1, "status during run");
        axi_write(REG_CTRL, 32'h1, $urandom % 6);   // restart while busy has no effect
        axi_write(REG_STATUS, 32'h0, $urandom % 6);
        axi_read(REG_STATUS, $urandom % 6, rd);
        check(rd, 32'h1, "status after write to status");
        axi_read(4'hc, $urandom % 6, rd);
        check(rd, 32'h0, "unmapped offset");
    endtask

    always @(negedge clk)
    begin
        logic [DATA_W-1:0] exp;
        if (nrst && pool_valid)
        begin
            if (expect_q.size() == 0)
                abort_run("pool_valid was raised while no pooled value was expected");
            else
            begin
                exp = expect_q.pop_front();
                check(pool_data, exp, "pooled value");
            end
        end
    end

    initial
    begin
        int limit;
        limit = 4 * MAP_SIZE * MAP_SIZE * 4 + 2000;   // four runs with generous gaps
        repeat (limit) @(posedge clk);
        abort_run("timeout: the run did not complete in the allowed number of cycles");
    end

    initial
    begin
        logic [31:0] rd;
        seed = 32'ha9cd867a;
        void'($urandom(seed));
        nrst      = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (3) @(negedge clk);
        nrst = 1'b1;

        axi_read(REG_STATUS, 0, rd);
        check(rd, 32'h0, "status after reset");
        axi_read(REG_OUT_COUNT, 0, rd);
        check(rd, 32'h0, "output count after reset");
        // without a start the monitor must see no pool_valid
        repeat (100)
        begin
            @(negedge clk);
            pix_valid = 1'($urandom);
            pix_data  = 16'($urandom);
        end
        @(negedge clk);
        pix_valid = 1'b0;

        do_run(1'b0, 0);
        do_run(1'b0, 30);
        do_run(1'b1, 10);

        fill_map(1'b0);
        build_model();
        axi_write(REG_CTRL, 32'h1, 0);
        fork
            stream_map(0);
            access_regs_during_run();
        join
        finish_run();
        axi_write(REG_STATUS, 32'hffffffff, 2);
        axi_read(REG_STATUS, 3, rd);
        check(rd, 32'h2, "status after write to status when idle");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
